/* design/cache_geom_pkg.sv */
//==========================================================================
// cache geometry
// address, word and line widths of the direct-mapped L1 data cache,
// plus the default index width that the top level hands down
//==========================================================================

package cache_geom_pkg;

  //========================================================================
  // widths
  //========================================================================
  localparam int ADDR_BITS      = 32;  // byte address
  localparam int WORD_BITS      = 32;  // core and memory word
  localparam int OFFSET_BITS    = 4;   // byte within a 16 byte line
  localparam int WORDS_PER_LINE = 4;   // refill beats per line
  localparam int DEF_INDEX_BITS = 6;   // 64 lines

  //========================================================================
  // types
  //========================================================================
  // byte address from the core
  typedef logic [ADDR_BITS-1:0] addr_t;

  // one data word, also one memory beat
  typedef logic [WORD_BITS-1:0] word_t;

  // a whole line, word 0 in the low bits
  typedef logic [WORDS_PER_LINE*WORD_BITS-1:0] line_t;

  // one write enable per byte of a line
  typedef logic [WORDS_PER_LINE*WORD_BITS/8-1:0] byte_en_t;

  // word number inside a line
  typedef logic [$clog2(WORDS_PER_LINE)-1:0] beat_t;

endpackage

/* design/access_pkg.sv */
//==========================================================================
// access encodings
// access-size code seen on both the core and the memory port, and the
// states of the cache controller
//==========================================================================

package access_pkg;

  // bit 2 set means zero extension on loads
  typedef logic [2:0] size_t;

  //========================================================================
  // size codes
  //========================================================================
  localparam size_t SIZE_BYTE   = 3'b000;
  localparam size_t SIZE_HALF   = 3'b001;
  localparam size_t SIZE_WORD   = 3'b010;
  localparam size_t SIZE_BYTE_U = 3'b100;
  localparam size_t SIZE_HALF_U = 3'b101;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,       // waiting for core_req
    LOOKUP,     // tag compare on the latched address
    WRITE_MEM,  // single write-through beat
    REFILL,     // four read beats into the line
    RESPOND     // core_wait low, load data valid
  } ctrl_state_t;

endpackage

/* design/tag_store.sv */
//==========================================================================
// tag store
// tag array and valid bits, one entry per line
// gives hit for the latched address, installs a tag when a refill ends
//==========================================================================

`timescale 1ns/1ps

module tag_store #(
  parameter int INDEX_BITS = cache_geom_pkg::DEF_INDEX_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  cache_geom_pkg::addr_t lookup_addr,  // latched request address
  input  logic                  install_en,   // last refill beat
  output logic                  hit
);

  import cache_geom_pkg::*;

  localparam int LINES    = 1 << INDEX_BITS;
  localparam int TAG_BITS = ADDR_BITS - INDEX_BITS - OFFSET_BITS;

  logic [TAG_BITS-1:0]   tag_mem [LINES];  // one tag per line
  logic [LINES-1:0]      valid;
  logic [INDEX_BITS-1:0] index;
  logic [TAG_BITS-1:0]   addr_tag;

  assign index    = lookup_addr[OFFSET_BITS +: INDEX_BITS];
  assign addr_tag = lookup_addr[ADDR_BITS-1 -: TAG_BITS];

  // combinational read and compare
  assign hit = valid[index] && (tag_mem[index] == addr_tag);

  //========================================================================
  // install
  //========================================================================
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid <= '0;  // all lines empty
    end else if (install_en) begin
      valid[index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (install_en) begin
      tag_mem[index] <= addr_tag;  // overwrites the evicted tag
    end
  end

  // refill only runs after a lookup miss so the line cannot hit here
  a_install_on_miss: assert property (
    @(posedge clk) disable iff (rst) install_en |-> !hit
  ) else $error("tag install while the address already hits");

endmodule

/* design/data_store.sv */
//==========================================================================
// data store
// line storage of the cache, read combinationally by word
// store hits merge bytes into the line, refill writes one word per beat
// store data arrives already placed in its byte lanes of the word
//==========================================================================

`timescale 1ns/1ps

module data_store #(
  parameter int INDEX_BITS = cache_geom_pkg::DEF_INDEX_BITS
) (
  input  logic                  clk,
  input  cache_geom_pkg::addr_t line_addr,    // latched request address
  input  logic                  store_en,     // store hit, beat done
  input  cache_geom_pkg::word_t store_data,
  input  access_pkg::size_t     store_size,
  input  logic                  refill_en,
  input  cache_geom_pkg::beat_t refill_beat,
  input  cache_geom_pkg::word_t refill_data,  // straight from D_out
  output cache_geom_pkg::word_t rd_word
);

  import cache_geom_pkg::*;
  import access_pkg::*;

  localparam int LINES      = 1 << INDEX_BITS;
  localparam int LINE_BYTES = $bits(byte_en_t);

  line_t                  line_mem [LINES];
  logic [INDEX_BITS-1:0]  index;
  logic [OFFSET_BITS-1:0] offset;
  beat_t                  word_sel;
  logic [3:0]             size_mask;   // bytes touched, word relative
  byte_en_t               store_mask;
  line_t                  store_lane;

  assign index    = line_addr[OFFSET_BITS +: INDEX_BITS];
  assign offset   = line_addr[OFFSET_BITS-1:0];
  assign word_sel = line_addr[OFFSET_BITS-1:2];

  //========================================================================
  // store lanes
  //========================================================================
  always_comb begin
    case (store_size)
      SIZE_BYTE, SIZE_BYTE_U: size_mask = 4'b0001;
      SIZE_HALF, SIZE_HALF_U: size_mask = 4'b0011;
      default:                size_mask = 4'b1111;  // word
    endcase
  end

  assign store_mask = byte_en_t'(size_mask) << offset;
  assign store_lane = line_t'(store_data) << (WORD_BITS * word_sel);  // word slot

  always_ff @(posedge clk) begin
    if (store_en) begin
      for (int i = 0; i < LINE_BYTES; i++) begin
        if (store_mask[i]) line_mem[index][8*i +: 8] <= store_lane[8*i +: 8];
      end
    end else if (refill_en) begin
      line_mem[index][refill_beat*WORD_BITS +: WORD_BITS] <= refill_data;
    end
  end

  // addressed word of the indexed line
  assign rd_word = line_mem[index][word_sel*WORD_BITS +: WORD_BITS];

  // a store hit and a refill beat never share a cycle
  a_one_writer: assert property (
    @(posedge clk) !(store_en && refill_en)
  ) else $error("store merge and refill write in the same cycle");

endmodule

/* design/cache_ctrl.sv */
//==========================================================================
// cache controller
// latches the core request, runs the lookup / write-through / refill FSM,
// counts refill beats and drives the word-wide memory port
//==========================================================================

`timescale 1ns/1ps

module cache_ctrl #(
  parameter int INDEX_BITS = cache_geom_pkg::DEF_INDEX_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  core_req,
  input  logic                  core_write,   // 1 = store
  input  cache_geom_pkg::addr_t core_addr,
  input  cache_geom_pkg::word_t core_in,
  input  access_pkg::size_t     core_type,
  input  logic                  hit,
  input  logic                  D_wait,
  output cache_geom_pkg::addr_t req_addr,
  output cache_geom_pkg::word_t req_data,
  output access_pkg::size_t     req_size,
  output logic                  store_en,
  output logic                  refill_en,
  output cache_geom_pkg::beat_t refill_beat,
  output logic                  install_en,
  output logic                  core_wait,
  output logic                  D_req,
  output logic                  D_write,
  output cache_geom_pkg::addr_t D_addr,
  output cache_geom_pkg::word_t D_in,
  output access_pkg::size_t     D_type
);

  import cache_geom_pkg::*;
  import access_pkg::*;

  localparam int    TAG_BITS  = ADDR_BITS - INDEX_BITS - OFFSET_BITS;
  localparam beat_t LAST_BEAT = beat_t'(WORDS_PER_LINE - 1);

  ctrl_state_t state, state_nx;
  beat_t       beat;
  logic        req_write;
  logic        beat_done;     // memory beat completes this edge
  logic        core_aligned;
  addr_t       refill_addr;

  //========================================================================
  // request latch and state
  //========================================================================
  always_ff @(posedge clk) begin
    if (state == IDLE && core_req) begin  // accept edge
      req_addr  <= core_addr;
      req_data  <= core_in;
      req_size  <= core_type;
      req_write <= core_write;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= IDLE;
      beat  <= '0;
    end else begin
      state <= state_nx;
      if (refill_en) beat <= beat + beat_t'(1);  // wraps to 0 after beat 3
    end
  end

  always_comb begin
    state_nx = state;
    case (state)
      IDLE:      if (core_req) state_nx = LOOKUP;
      LOOKUP: begin
        if (req_write)  state_nx = WRITE_MEM;  // write-through, hit or miss
        else if (hit)   state_nx = RESPOND;
        else            state_nx = REFILL;
      end
      WRITE_MEM: if (beat_done) state_nx = RESPOND;
      REFILL:    if (install_en) state_nx = RESPOND;
      RESPOND:   state_nx = IDLE;
      default:   state_nx = IDLE;
    endcase
  end

  //========================================================================
  // strobes and memory port
  //========================================================================
  assign beat_done   = D_req && !D_wait;
  assign store_en    = (state == WRITE_MEM) && beat_done && hit;  // no allocate
  assign refill_en   = (state == REFILL) && beat_done;
  assign install_en  = refill_en && (beat == LAST_BEAT);
  assign refill_beat = beat;
  assign core_wait   = state inside {LOOKUP, WRITE_MEM, REFILL};

  // line base plus beat, word aligned
  assign refill_addr = {req_addr[ADDR_BITS-1 -: TAG_BITS],
                        req_addr[OFFSET_BITS +: INDEX_BITS], beat, 2'b00};

  assign D_req   = (state == WRITE_MEM) || (state == REFILL);
  assign D_write = (state == WRITE_MEM);
  assign D_addr  = (state == REFILL) ? refill_addr : req_addr;
  assign D_in    = req_data;
  assign D_type  = (state == REFILL) ? SIZE_WORD : req_size;

  always_comb begin
    case (core_type)
      SIZE_BYTE, SIZE_BYTE_U: core_aligned = 1'b1;
      SIZE_HALF, SIZE_HALF_U: core_aligned = !core_addr[0];
      SIZE_WORD:              core_aligned = (core_addr[1:0] == 2'b00);
      default:                core_aligned = 1'b0;  // unused codes
    endcase
  end

  a_req_aligned: assert property (
    @(posedge clk) disable iff (rst) (state == IDLE && core_req) |-> core_aligned
  ) else $error("misaligned core request");

  // memory sees a steady address until it drops D_wait
  a_addr_hold: assert property (
    @(posedge clk) disable iff (rst) (D_req && D_wait) |=> $stable(D_addr)
  ) else $error("D_addr changed while the memory was stalling");

endmodule

/* design/load_align.sv */
//==========================================================================
// load alignment
// picks the byte or half-word out of the read word and extends it
//==========================================================================

`timescale 1ns/1ps

module load_align (
  input  cache_geom_pkg::word_t word_in,    // addressed word of the line
  input  logic [1:0]            byte_off,   // address bits 1:0
  input  access_pkg::size_t     size,
  output cache_geom_pkg::word_t load_data
);

  import access_pkg::*;

  logic [7:0]  sel_byte;
  logic [15:0] sel_half;

  // lane select by offset
  assign sel_byte = word_in[8*byte_off +: 8];
  assign sel_half = word_in[16*byte_off[1] +: 16];  // halves are aligned

  //========================================================================
  // extension
  //========================================================================
  always_comb begin
    case (size)
      SIZE_BYTE:   load_data = {{24{sel_byte[7]}}, sel_byte};  // signed
      SIZE_BYTE_U: load_data = {24'b0, sel_byte};
      SIZE_HALF:   load_data = {{16{sel_half[15]}}, sel_half};
      SIZE_HALF_U: load_data = {16'b0, sel_half};
      default:     load_data = word_in;  // full word
    endcase
  end

endmodule

/* design/l1d_cache.sv */
//==========================================================================
// L1 data cache, top level
// direct mapped, write-through, no allocate on store miss
// 16 byte lines refilled in four word beats from the memory port
//==========================================================================

`timescale 1ns/1ps

module l1d_cache #(
  parameter int INDEX_BITS = cache_geom_pkg::DEF_INDEX_BITS
) (
  input  logic                  clk,
  input  logic                  rst,
  // core side
  input  logic                  core_req,
  input  logic                  core_write,  // 1 = store
  input  cache_geom_pkg::addr_t core_addr,
  input  cache_geom_pkg::word_t core_in,
  input  access_pkg::size_t     core_type,
  output logic                  core_wait,
  output cache_geom_pkg::word_t core_out,    // valid in RESPOND for loads
  // memory side
  output logic                  D_req,
  output logic                  D_write,
  output cache_geom_pkg::addr_t D_addr,
  output cache_geom_pkg::word_t D_in,
  output access_pkg::size_t     D_type,
  input  cache_geom_pkg::word_t D_out,
  input  logic                  D_wait
);

  import cache_geom_pkg::*;
  import access_pkg::*;

  addr_t req_addr;
  word_t req_data;
  size_t req_size;
  word_t rd_word;
  beat_t refill_beat;
  logic  hit;
  logic  store_en, refill_en, install_en;

  //========================================================================
  // lookup, control, storage, load result
  //========================================================================
  tag_store #(.INDEX_BITS(INDEX_BITS)) u_tag (
    .clk(clk), .rst(rst),
    .lookup_addr(req_addr),
    .install_en (install_en),
    .hit        (hit)
  );

  cache_ctrl #(.INDEX_BITS(INDEX_BITS)) u_ctrl (
    .clk(clk), .rst(rst),
    .core_req(core_req), .core_write(core_write), .core_addr(core_addr),
    .core_in(core_in), .core_type(core_type),
    .hit(hit), .D_wait(D_wait),
    .req_addr(req_addr), .req_data(req_data), .req_size(req_size),
    .store_en(store_en), .refill_en(refill_en), .refill_beat(refill_beat),
    .install_en(install_en), .core_wait(core_wait),
    .D_req(D_req), .D_write(D_write), .D_addr(D_addr),
    .D_in(D_in), .D_type(D_type)
  );

  data_store #(.INDEX_BITS(INDEX_BITS)) u_data (
    .clk(clk),
    .line_addr(req_addr),
    .store_en(store_en), .store_data(req_data), .store_size(req_size),
    .refill_en(refill_en), .refill_beat(refill_beat), .refill_data(D_out),
    .rd_word(rd_word)
  );

  load_align u_align (
    .word_in  (rd_word),
    .byte_off (req_addr[1:0]),
    .size     (req_size),
    .load_data(core_out)
  );

endmodule

/* sim/mem_model.sv */
//==========================================================================
// memory model for the cache testbench
// word-wide port with level strobes, random stall of 0 to 3 cycles per
// beat, byte array that the testbench also reads as its reference
//==========================================================================

`timescale 1ns/1ps

module mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        D_req,
  input  logic        D_write,
  input  logic [31:0] D_addr,
  input  logic [31:0] D_in,     // store data already in its byte lanes
  input  logic [2:0]  D_type,
  output logic [31:0] D_out,
  output logic        D_wait
);

  logic [7:0]  mem [0:65535];  // 64 KiB window around the test addresses
  logic [15:0] base;           // word aligned address of the beat
  logic [3:0]  lanes;          // bytes written by a store beat
  int          stall;
  int          seed;
  logic [31:0] fill;

  initial begin
    seed   = 32'h2a1e9411;
    stall  = 0;
    D_wait = 1'b0;
    for (int w = 0; w < 16384; w++) begin
      fill = (w * 4) ^ 32'h5a5a0000;  // whole address in every word
      for (int b = 0; b < 4; b++) mem[w*4 + b] = fill[8*b +: 8];
    end
  end

  assign base  = {D_addr[15:2], 2'b00};
  assign D_out = {mem[base | 16'd3], mem[base | 16'd2], mem[base | 16'd1], mem[base]};

  always_comb begin
    case (D_type[1:0])
      2'b00:   lanes = 4'b0001 << D_addr[1:0];
      2'b01:   lanes = 4'b0011 << D_addr[1:0];
      default: lanes = 4'b1111;
    endcase
  end

  // stall draw and D_wait on the falling edge
  always @(negedge clk) begin
    if (rst || !D_req) begin
      D_wait <= 1'b0;
    end else begin
      if (!D_wait) begin
        stall = $random(seed) & 3;  // fresh beat after a low D_wait
      end
      if (stall > 0) begin
        D_wait <= 1'b1;
        stall  = stall - 1;
      end else begin
        D_wait <= 1'b0;
      end
    end
  end

  // store bytes land in the array as the beat completes
  always @(posedge clk) begin
    if (!rst && D_req && !D_wait && D_write) begin
      for (int b = 0; b < 4; b++) begin
        if (lanes[b]) mem[base | 16'(b)] <= D_in[8*b +: 8];
      end
    end
  end

endmodule

/* sim/tb_l1d_cache.sv */
//==========================================================================
// testbench for the L1 data cache
// table of loads and stores applied in a loop, memory beats logged and
// checked, load results compared with bytes from the memory model
//==========================================================================

`timescale 1ns/1ps

module tb_l1d_cache;

  localparam int TIMEOUT = 200;  // cycles per wait loop

  typedef struct {
    bit          wr;
    logic [31:0] addr;
    logic [2:0]  size;
    logic [31:0] data;  // right aligned and shifted into its lanes when driven
    bit          hit;
  } step_t;

  logic        clk, rst;
  logic        core_req, core_write, core_wait, D_req, D_write, D_wait;
  logic [31:0] core_addr, core_in, core_out, D_addr, D_in, D_out;
  logic [2:0]  core_type, D_type;

  step_t       steps[$];
  int          beat_total;
  logic        rec_wr   [256];
  logic [31:0] rec_addr [256];
  logic [31:0] rec_data [256];
  logic [2:0]  rec_type [256];

  l1d_cache u_dut (
    .clk(clk), .rst(rst),
    .core_req(core_req), .core_write(core_write), .core_addr(core_addr),
    .core_in(core_in), .core_type(core_type),
    .core_wait(core_wait), .core_out(core_out),
    .D_req(D_req), .D_write(D_write), .D_addr(D_addr), .D_in(D_in),
    .D_type(D_type), .D_out(D_out), .D_wait(D_wait)
  );

  mem_model u_mem (
    .clk(clk), .rst(rst), .D_req(D_req), .D_write(D_write), .D_addr(D_addr),
    .D_in(D_in), .D_type(D_type), .D_out(D_out), .D_wait(D_wait)
  );

  always #10 clk = ~clk;

  // beat log sampled like a flop on the completing edge
  always @(posedge clk) begin
    if (!rst && D_req && !D_wait) begin
      rec_wr[beat_total[7:0]]   = D_write;
      rec_addr[beat_total[7:0]] = D_addr;
      rec_data[beat_total[7:0]] = D_in;
      rec_type[beat_total[7:0]] = D_type;
      beat_total = beat_total + 1;
    end
  end

  //========================================================================
  // helpers
  //========================================================================
  task automatic report_error(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("TESTS FAILED");
    $fatal(1, "check failed");
  endtask

  task automatic report_timeout(input string what);
    $display("timed out waiting for %s", what);
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  endtask

  task automatic check(input bit ok, input string msg);
    assert (ok) else report_error(msg);
  endtask

  task automatic add_step(input bit wr, input logic [31:0] addr, input logic [2:0] size,
                          input logic [31:0] data, input bit hit);
    step_t s;
    s.wr   = wr;
    s.addr = addr;
    s.size = size;
    s.data = data;
    s.hit  = hit;
    steps.push_back(s);
  endtask

  // little endian word straight from the memory bytes
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [15:0] b;
    b = {addr[15:2], 2'b00};
    return {u_mem.mem[b | 16'd3], u_mem.mem[b | 16'd2], u_mem.mem[b | 16'd1], u_mem.mem[b]};
  endfunction

  // byte or half by offset then sign or zero extension
  function automatic logic [31:0] expect_load(input logic [31:0] w, input logic [1:0] off,
                                              input logic [2:0] size);
    logic [7:0]  b;
    logic [15:0] h;
    b = 8'(w >> (8 * off));
    h = 16'(w >> (8 * off));
    if (size == 3'b000) return {{24{b[7]}}, b};
    if (size == 3'b100) return {24'h0, b};
    if (size == 3'b001) return {{16{h[15]}}, h};
    if (size == 3'b101) return {16'h0, h};
    return w;
  endfunction

  task automatic run_step(input step_t s);
    int          n;
    int          wait_cyc;
    int          first;
    logic [31:0] lane;
    logic [31:0] line;
    lane = s.data << (8 * s.addr[1:0]);  // core supplies lane-placed data
    line = {s.addr[31:4], 4'h0};
    first = beat_total;
    core_req   = 1'b1;
    core_write = s.wr;
    core_addr  = s.addr;
    core_in    = lane;
    core_type  = s.size;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n > TIMEOUT) report_timeout("request acceptance");
    end while (!core_wait);
    wait_cyc = 0;
    while (core_wait) begin
      @(negedge clk);
      wait_cyc++;
      if (wait_cyc > TIMEOUT) report_timeout("core_wait to fall");
    end
    // falling edge inside RESPOND
    if (s.wr) begin
      check(beat_total - first == 1, $sformatf("store %h: %0d beats", s.addr,
            beat_total - first));
      check(rec_wr[first[7:0]] == 1'b1 && rec_addr[first[7:0]] == s.addr &&
            rec_data[first[7:0]] == lane && rec_type[first[7:0]] == s.size,
            $sformatf("store %h: write beat %h %h %0d", s.addr, rec_addr[first[7:0]],
                      rec_data[first[7:0]], rec_type[first[7:0]]));
    end else begin
      if (s.hit) begin
        check(beat_total == first && wait_cyc == 1,
              $sformatf("load %h: expected hit, %0d beats", s.addr, beat_total - first));
      end else begin
        check(beat_total - first == 4,
              $sformatf("load %h: expected 4 refill beats, got %0d", s.addr,
                        beat_total - first));
        for (int k = 0; k < 4; k++) begin
          check(!rec_wr[(first + k) % 256] && rec_type[(first + k) % 256] == 3'b010 &&
                rec_addr[(first + k) % 256] == line + 32'(4 * k),
                $sformatf("load %h: refill beat %0d at %h", s.addr, k,
                          rec_addr[(first + k) % 256]));
        end
      end
      check(core_out == expect_load(mem_word(s.addr), s.addr[1:0], s.size),
            $sformatf("load %h: core_out %h, expected %h", s.addr, core_out,
                      expect_load(mem_word(s.addr), s.addr[1:0], s.size)));
    end
    core_req = 1'b0;
    @(negedge clk);  // back in IDLE
  endtask

  //========================================================================
  // stimulus table and main sequence
  //========================================================================
  initial begin
    clk = 1'b0;
    rst = 1'b1;
    core_req = 1'b0;
    core_write = 1'b0;
    core_addr = '0;
    core_in = '0;
    core_type = 3'b010;
    beat_total = 0;

    add_step(0, 32'h1000, 3'b010, 0, 0);            // cold miss
    add_step(0, 32'h1004, 3'b010, 0, 1);
    add_step(1, 32'h1008, 3'b010, 32'h80f17f01, 1); // word store hit
    add_step(0, 32'h1008, 3'b010, 0, 1);
    for (int o = 0; o < 4; o++) begin
      add_step(0, 32'h1008 + o, 3'b000, 0, 1);      // signed byte
      add_step(0, 32'h1008 + o, 3'b100, 0, 1);      // unsigned byte
    end
    for (int o = 0; o < 4; o += 2) begin
      add_step(0, 32'h1008 + o, 3'b001, 0, 1);
      add_step(0, 32'h1008 + o, 3'b101, 0, 1);
    end
    add_step(1, 32'h100e, 3'b001, 32'h0000beef, 1); // half store hit
    add_step(0, 32'h100c, 3'b010, 0, 1);
    add_step(1, 32'h2043, 3'b000, 32'h000000a5, 0); // store miss without allocate
    add_step(0, 32'h2043, 3'b100, 0, 0);
    add_step(0, 32'h1400, 3'b010, 0, 0);            // same index evicts 0x1000
    add_step(0, 32'h1000, 3'b010, 0, 0);
    add_step(1, 32'h1001, 3'b000, 32'h0000007e, 1);
    add_step(0, 32'h1000, 3'b010, 0, 1);
    add_step(1, 32'h1404, 3'b010, 32'hcafe0123, 0); // store to evicted line
    add_step(0, 32'h1404, 3'b010, 0, 0);

    repeat (3) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check(!core_wait && !D_req, "core_wait or D_req high after reset");
    foreach (steps[i]) run_step(steps[i]);

    $display("TESTS PASSED");
    $finish;
  end

endmodule

/* src.f */
design/cache_geom_pkg.sv
design/access_pkg.sv
design/tag_store.sv
design/data_store.sv
design/cache_ctrl.sv
design/load_align.sv
design/l1d_cache.sv
sim/mem_model.sv
sim/tb_l1d_cache.sv

/* Makefile */
# Verilator build and run of the L1 data cache testbench

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_l1d_cache \
		-f src.f -o tb_l1d_cache
	./obj_dir/tb_l1d_cache

clean:
	rm -rf obj_dir
